// File: verilog/bridge_pkg.sv
package bridge_pkg;

	// ==================================================================
	// Slot map
	// ==================================================================

	// Timer peripherals behind the bridge
	localparam int unsigned NUM_TIMERS = 4;

	// Width of a slot index on the far side
	localparam int unsigned SLOT_BITS = 2;

	// Near address [27:24] selects the peripheral slot
	localparam int unsigned SLOT_MSB = 27;
	localparam int unsigned SLOT_LSB = 24;

	// Word index within a peripheral
	localparam int unsigned REG_MSB = 3;
	localparam int unsigned REG_LSB = 2;

	// ==================================================================
	// Encodings
	// ==================================================================

	// Timer register map
	typedef enum logic [1:0] {
		REG_CTRL    = 2'd0,	// [0] count enable, [1] interrupt enable
		REG_COMPARE = 2'd1,
		REG_COUNT   = 2'd2,	// read only
		REG_STATUS  = 2'd3	// [0] pending, write 1 to clear
	} timer_reg_e;

	// Near-side transaction states
	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_ACCESS = 2'd1,
		ST_WAIT   = 2'd2,
		ST_DONE   = 2'd3
	} bridge_state_e;

endpackage

// File: verilog/far_bus_if.sv
`timescale 1ns/1ns

interface far_bus_if import bridge_pkg::*; ();

	// Common request side, driven by the bridge
	logic                 request;
	logic                 rw;
	logic [SLOT_BITS-1:0] slot;
	timer_reg_e           reg_sel;
	logic [31:0]          wdata;

	// One entry per timer slot
	logic [NUM_TIMERS-1:0][31:0] rdata;
	logic [NUM_TIMERS-1:0]       ready;
	logic [NUM_TIMERS-1:0]       irq;

	// Response of the addressed slot
	logic [31:0] sel_rdata;
	logic        sel_ready;

	modport bridge (
		output request, rw, slot, reg_sel, wdata,
		input  sel_rdata, sel_ready
	);

	modport unit (
		input  request, rw, slot, reg_sel, wdata,
		output rdata, ready, irq
	);

	modport merge (
		input  slot, rdata, ready, irq,
		output sel_rdata, sel_ready
	);

endinterface

// File: verilog/bus_bridge.sv
`timescale 1ns/1ns

module bus_bridge import bridge_pkg::*; (
	input  logic        clock,
	input  logic        i_rst_n,

	// Near side
	input  logic        i_request,
	input  logic        i_rw,
	input  logic [27:0] i_address,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic        o_ready,

	// Far side
	far_bus_if.bridge   far
);

	bridge_state_e        state_q;
	logic                 mapped_q;
	logic                 ready_q;

	logic                 rw_q;
	logic [SLOT_BITS-1:0] slot_q;
	timer_reg_e           reg_q;
	logic [31:0]          wdata_q;
	logic [31:0]          rdata_q;

	logic                 addr_mapped;
	logic                 accept;
	logic                 wait_done;

	// ==================================================================
	// Decode
	// ==================================================================

	// Slots past the last timer have nothing behind them
	assign addr_mapped = 32'(i_address[SLOT_MSB:SLOT_LSB]) < NUM_TIMERS;

	// New transaction only from idle
	assign accept = (state_q == ST_IDLE) && i_request;

	// Unmapped slots never see a far request, so no ready to wait for
	assign wait_done = (state_q == ST_WAIT) && (!mapped_q || far.sel_ready);

	// ==================================================================
	// Transaction FSM
	// ==================================================================

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q  <= ST_IDLE;
			mapped_q <= 1'b0;
			ready_q  <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (i_request) begin
						mapped_q <= addr_mapped;
						state_q  <= ST_ACCESS;
					end
				end
				ST_ACCESS: begin
					// Far request is out this cycle
					state_q <= ST_WAIT;
				end
				ST_WAIT: begin
					if (wait_done) begin
						state_q <= ST_DONE;
					end
				end
				ST_DONE: begin
					// First cycle raises ready, second drops it and frees the bridge
					if (ready_q) begin
						ready_q <= 1'b0;
						state_q <= ST_IDLE;
					end else begin
						ready_q <= 1'b1;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Latched near transaction and captured response
	always_ff @(posedge clock) begin
		if (accept) begin
			rw_q    <= i_rw;
			slot_q  <= i_address[SLOT_LSB +: SLOT_BITS];
			reg_q   <= timer_reg_e'(i_address[REG_MSB:REG_LSB]);
			wdata_q <= i_wdata;
		end
		if (wait_done) begin
			// Writes and empty slots answer with zero
			rdata_q <= (mapped_q && !rw_q) ? far.sel_rdata : 32'd0;
		end
	end

	// ==================================================================
	// Outputs
	// ==================================================================

	assign far.request = (state_q == ST_ACCESS) && mapped_q;
	assign far.rw      = rw_q;
	assign far.slot    = slot_q;
	assign far.reg_sel = reg_q;
	assign far.wdata   = wdata_q;

	assign o_rdata = rdata_q;
	assign o_ready = ready_q;

endmodule

// File: verilog/timer_unit.sv
`timescale 1ns/1ns

module timer_unit import bridge_pkg::*; #(
	parameter logic [SLOT_BITS-1:0] SLOT = '0
) (
	input  logic    clock,
	input  logic    i_rst_n,
	far_bus_if.unit far
);

	logic [1:0]  ctrl_q;
	logic [31:0] compare_q;
	logic [31:0] count_q;
	logic        pending_q;
	logic        ready_q;
	logic [31:0] rdata_q;

	logic        hit;
	logic        wr_hit;
	logic        count_en;
	logic        irq_en;
	logic        match;
	logic [31:0] read_value;

	// ==================================================================
	// Far-side decode
	// ==================================================================

	assign hit    = far.request && (far.slot == SLOT);
	assign wr_hit = hit && far.rw;

	assign count_en = ctrl_q[0];
	assign irq_en   = ctrl_q[1];

	// Wrap point of the counter
	assign match = count_en && (count_q == compare_q);

	always_comb begin
		case (far.reg_sel)
			REG_CTRL:    read_value = {30'd0, ctrl_q};
			REG_COMPARE: read_value = compare_q;
			REG_COUNT:   read_value = count_q;
			REG_STATUS:  read_value = {31'd0, pending_q};
			default:     read_value = 32'd0;
		endcase
	end

	// ==================================================================
	// Registers and counter
	// ==================================================================

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ctrl_q    <= 2'd0;
			compare_q <= 32'd0;
			count_q   <= 32'd0;
			pending_q <= 1'b0;
			ready_q   <= 1'b0;
		end else begin
			// One-cycle answer to a one-cycle request
			ready_q <= hit;

			if (match) begin
				count_q <= 32'd0;
			end else if (count_en) begin
				count_q <= count_q + 32'd1;
			end

			if (wr_hit) begin
				case (far.reg_sel)
					REG_CTRL: begin
						ctrl_q <= far.wdata[1:0];
					end
					REG_COMPARE: begin
						compare_q <= far.wdata;
					end
					REG_STATUS: begin
						if (far.wdata[0]) begin
							pending_q <= 1'b0;
						end
					end
					default: begin
						// Count is read only
					end
				endcase
			end

			// A new match wins over a clear in the same cycle
			if (match) begin
				pending_q <= 1'b1;
			end
		end
	end

	// Value seen before any write in the same access
	always_ff @(posedge clock) begin
		if (hit) begin
			rdata_q <= read_value;
		end
	end

	// ==================================================================
	// Slot outputs
	// ==================================================================

	assign far.rdata[SLOT] = rdata_q;
	assign far.ready[SLOT] = ready_q;
	assign far.irq[SLOT]   = pending_q & irq_en;

endmodule

// File: verilog/response_merge.sv
`timescale 1ns/1ns

module response_merge (
	input  logic     clock,
	input  logic     i_rst_n,
	far_bus_if.merge far,
	output logic     o_interrupt
);

	logic irq_q;
	logic irq_any;

	// ==================================================================
	// Read response
	// ==================================================================

	// Only the addressed slot can be answering
	assign far.sel_rdata = far.rdata[far.slot];
	assign far.sel_ready = far.ready[far.slot];

	// ==================================================================
	// Interrupt
	// ==================================================================

	// Any timer pending with its enable set
	assign irq_any = |far.irq;

	always_ff @(posedge clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			irq_q <= 1'b0;
		end else begin
			irq_q <= irq_any;
		end
	end

	assign o_interrupt = irq_q;

endmodule

// File: verilog/north_bridge.sv
`timescale 1ns/1ns

module north_bridge import bridge_pkg::*; (
	input  logic        clock,
	input  logic        i_rst_n,

	// Near bus
	input  logic        i_request,
	input  logic        i_rw,
	input  logic [27:0] i_address,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic        o_ready,

	// Combined timer interrupt
	output logic        o_interrupt
);

	// Far bus shared by the bridge, the timers and the merge stage
	far_bus_if far_bus_i ();

	// ==================================================================
	// Near-side controller
	// ==================================================================

	bus_bridge bus_bridge_i (
		.clock     (clock),
		.i_rst_n   (i_rst_n),
		.i_request (i_request),
		.i_rw      (i_rw),
		.i_address (i_address),
		.i_wdata   (i_wdata),
		.o_rdata   (o_rdata),
		.o_ready   (o_ready),
		.far       (far_bus_i.bridge)
	);

	// ==================================================================
	// Timer slots
	// ==================================================================

	for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
		timer_unit #(
			.SLOT (SLOT_BITS'(i))
		) timer_unit_i (
			.clock   (clock),
			.i_rst_n (i_rst_n),
			.far     (far_bus_i.unit)
		);
	end

	// Response select and interrupt combine
	response_merge response_merge_i (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.far         (far_bus_i.merge),
		.o_interrupt (o_interrupt)
	);

endmodule

// File: test/tb_north_bridge.sv
`timescale 1ns/1ns

module tb_north_bridge import bridge_pkg::*; ();

	// Worst case run is a few thousand cycles
	localparam int CYCLE_LIMIT  = 20000;
	localparam int ACCESS_EDGES = 4;
	localparam int EDGE_LIMIT   = 16;
	localparam int POLL_LIMIT   = 64;
	localparam int RANDOM_OPS   = 200;

	logic        clock;
	logic        i_rst_n;
	logic        i_request;
	logic        i_rw;
	logic [27:0] i_address;
	logic [31:0] i_wdata;
	logic [31:0] o_rdata;
	logic        o_ready;
	logic        o_interrupt;

	// Reference state per timer
	logic [1:0]  model_ctrl    [NUM_TIMERS];
	logic [31:0] model_compare [NUM_TIMERS];
	logic [31:0] model_count   [NUM_TIMERS];
	logic        model_pending [NUM_TIMERS];
	// Edge at which the count last started or stopped
	int          model_start   [NUM_TIMERS];

	// Expected responses in issue order
	logic [31:0] exp_q [$];
	logic        chk_q [$];

	int cycle_count = 0;

	north_bridge north_bridge_i (
		.clock       (clock),
		.i_rst_n     (i_rst_n),
		.i_request   (i_request),
		.i_rw        (i_rw),
		.i_address   (i_address),
		.i_wdata     (i_wdata),
		.o_rdata     (o_rdata),
		.o_ready     (o_ready),
		.o_interrupt (o_interrupt)
	);

	always #5 clock = ~clock;

	// ==================================================================
	// Reference model
	// ==================================================================

	// Count after the given edge, wrapping to zero past the compare value
	function automatic logic [31:0] count_at_edge(input logic [1:0] idx, input int edge_no);
		logic [63:0] span;
		span = 64'(model_compare[idx]) + 64'd1;
		if (!model_ctrl[idx][0]) begin
			return model_count[idx];
		end
		return 32'((64'(model_count[idx]) + 64'(edge_no - model_start[idx])) % span);
	endfunction

	function automatic logic [31:0] model_read(input logic [3:0] slot, input logic [1:0] reg_idx,
		input int edge_no);
		logic [31:0] value;
		value = 32'd0;
		// Empty slots always read zero
		if (32'(slot) < NUM_TIMERS) begin
			case (timer_reg_e'(reg_idx))
				REG_CTRL:    value = {30'd0, model_ctrl[slot[1:0]]};
				REG_COMPARE: value = model_compare[slot[1:0]];
				REG_COUNT:   value = count_at_edge(slot[1:0], edge_no);
				REG_STATUS:  value = {31'd0, model_pending[slot[1:0]]};
				default:     value = 32'd0;
			endcase
		end
		return value;
	endfunction

	function automatic void model_write(
		input logic [3:0]  slot,
		input logic [1:0]  reg_idx,
		input logic [31:0] wdata,
		input int          edge_no
	);
		if (32'(slot) < NUM_TIMERS) begin
			// Running count is held at the write edge
			if (model_ctrl[slot[1:0]][0]) begin
				model_count[slot[1:0]] = count_at_edge(slot[1:0], edge_no);
			end
			model_start[slot[1:0]] = edge_no;
			case (timer_reg_e'(reg_idx))
				REG_CTRL:    model_ctrl[slot[1:0]] = wdata[1:0];
				REG_COMPARE: model_compare[slot[1:0]] = wdata;
				REG_STATUS:  if (wdata[0]) model_pending[slot[1:0]] = 1'b0;
				default:     ;
			endcase
		end
	endfunction

	// ==================================================================
	// Bus tasks
	// ==================================================================

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic bus_access(
		input  logic        rw,
		input  logic [3:0]  slot,
		input  logic [1:0]  reg_idx,
		input  logic [31:0] wdata,
		input  logic        check,
		output logic [31:0] rdata
	);
		int edges;
		int sample_edge;
		edges       = 0;
		sample_edge = 0;
		@(posedge clock);
		i_request <= 1'b1;
		i_rw      <= rw;
		i_address <= {slot, 20'($urandom), reg_idx, 2'($urandom)};
		i_wdata   <= wdata;
		// First pass counts the edge that samples the request
		do begin
			@(posedge clock);
			edges++;
			@(negedge clock);
			if (edges == 1) begin
				// Read value is the one before the far access edge
				sample_edge = cycle_count;
				exp_q.push_back(model_read(slot, reg_idx, sample_edge));
				chk_q.push_back(check && (!rw || 32'(slot) >= NUM_TIMERS));
			end
		end while (!o_ready && edges < EDGE_LIMIT);
		assert (o_ready) else begin
			fail_run($sformatf("no ready from slot %0d within %0d edges", slot, EDGE_LIMIT));
		end
		assert (edges == ACCESS_EDGES) else begin
			fail_run($sformatf("MISMATCH latency: expected %h got %h", ACCESS_EDGES, edges));
		end
		rdata = o_rdata;
		if (rw) begin
			// Far write lands one edge after the sampling edge
			model_write(slot, reg_idx, wdata, sample_edge + 1);
		end
		@(posedge clock);
		i_request <= 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] slot, input logic [1:0] reg_idx,
		input logic [31:0] wdata);
		logic [31:0] rdata;
		bus_access(1'b1, slot, reg_idx, wdata, 1'b1, rdata);
	endtask

	task automatic read_reg(input logic [3:0] slot, input logic [1:0] reg_idx,
		input logic check, output logic [31:0] rdata);
		bus_access(1'b0, slot, reg_idx, 32'd0, check, rdata);
	endtask

	task automatic check_interrupt(input logic expected);
		@(negedge clock);
		assert (o_interrupt == expected) else begin
			fail_run($sformatf("MISMATCH o_interrupt: expected %h got %h", expected, o_interrupt));
		end
	endtask

	// ==================================================================
	// Compare and timeout
	// ==================================================================

	always @(negedge clock) begin
		logic [31:0] expected;
		logic        check;
		if (i_rst_n && o_ready) begin
			assert (exp_q.size() > 0) else begin
				fail_run("ready pulsed with no transaction open");
			end
			expected = exp_q.pop_front();
			check    = chk_q.pop_front();
			if (check) begin
				assert (o_rdata == expected) else begin
					fail_run($sformatf("MISMATCH o_rdata: expected %h got %h", expected, o_rdata));
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		assert (cycle_count < CYCLE_LIMIT) else begin
			fail_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
		end
	end

	// ==================================================================
	// Stimulus
	// ==================================================================

	initial begin
		logic [31:0] rdata;
		logic [31:0] value;
		logic [3:0]  slot;
		logic [1:0]  reg_idx;
		logic        rw;
		logic        seen;
		int          polls;
		void'($urandom(32'h2c0));
		clock     = 1'b0;
		i_rst_n   = 1'b0;
		i_request = 1'b0;
		i_rw      = 1'b0;
		i_address = 28'd0;
		i_wdata   = 32'd0;
		for (int s = 0; s < NUM_TIMERS; s++) begin
			model_ctrl[s]    = 2'd0;
			model_compare[s] = 32'd0;
			model_count[s]   = 32'd0;
			model_pending[s] = 1'b0;
			model_start[s]   = 0;
		end
		repeat (4) @(posedge clock);
		i_rst_n <= 1'b1;

		// Everything reads zero out of reset
		for (int s = 0; s < NUM_TIMERS; s++) begin
			for (int r = 0; r < 4; r++) begin
				read_reg(4'(s), 2'(r), 1'b1, rdata);
			end
		end
		check_interrupt(1'b0);

		// Compare and control read back, count runs briefly against a far compare
		for (int s = 0; s < NUM_TIMERS; s++) begin
			write_reg(4'(s), REG_COMPARE, $urandom | 32'h8000_0000);
			read_reg(4'(s), REG_COMPARE, 1'b1, rdata);
			write_reg(4'(s), REG_CTRL, $urandom);
			read_reg(4'(s), REG_CTRL, 1'b1, rdata);
			write_reg(4'(s), REG_CTRL, 32'd0);
			read_reg(4'(s), REG_COUNT, 1'b1, rdata);
		end

		// Empty slots answer with zero
		for (int s = NUM_TIMERS; s < 16; s++) begin
			read_reg(4'(s), 2'($urandom), 1'b1, rdata);
			write_reg(4'(s), 2'($urandom), $urandom);
		end

		// Count up to a near compare with the interrupt masked
		for (int s = 0; s < NUM_TIMERS; s++) begin
			value = model_count[s] + 32'd4 + 32'($urandom % 24);
			write_reg(4'(s), REG_COMPARE, value);
			write_reg(4'(s), REG_CTRL, 32'h1);
			seen  = 1'b0;
			polls = 0;
			while (!seen && polls < POLL_LIMIT) begin
				read_reg(4'(s), REG_COUNT, 1'b0, rdata);
				assert (rdata <= model_compare[s]) else begin
					fail_run($sformatf("MISMATCH count: expected at most %h got %h",
						model_compare[s], rdata));
				end
				read_reg(4'(s), REG_STATUS, 1'b0, rdata);
				seen = rdata[0];
				polls++;
			end
			assert (seen) else begin
				fail_run($sformatf("pending never set on slot %0d", s));
			end
			model_pending[s] = 1'b1;
			check_interrupt(1'b0);
		end

		// Stop each timer with its interrupt enabled
		for (int s = 0; s < NUM_TIMERS; s++) begin
			write_reg(4'(s), REG_CTRL, 32'h2);
			check_interrupt(1'b1);
		end
		for (int s = 0; s < NUM_TIMERS; s++) begin
			read_reg(4'(s), REG_COUNT, 1'b1, rdata);
			read_reg(4'(s), REG_STATUS, 1'b1, rdata);
		end

		// Interrupt holds until the last pending flag is cleared
		for (int s = 0; s < NUM_TIMERS; s++) begin
			write_reg(4'(s), REG_STATUS, 32'h1);
			check_interrupt(s < NUM_TIMERS - 1);
			read_reg(4'(s), REG_STATUS, 1'b1, rdata);
		end

		// Random traffic, counters held so the model stays exact
		for (int n = 0; n < RANDOM_OPS; n++) begin
			slot    = 4'($urandom % 6);
			reg_idx = 2'($urandom);
			rw      = 1'($urandom);
			value   = $urandom;
			if (reg_idx == REG_CTRL) begin
				value[0] = 1'b0;
			end
			bus_access(rw, slot, reg_idx, value, 1'b1, rdata);
		end

		repeat (2) @(posedge clock);
		$display("sim passed");
		$finish;
	end

endmodule

// File: north_bridge.f
verilog/bridge_pkg.sv
verilog/far_bus_if.sv
verilog/bus_bridge.sv
verilog/timer_unit.sv
verilog/response_merge.sv
verilog/north_bridge.sv
test/tb_north_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the north bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_north_bridge \
	-f north_bridge.f \
	-o sim_north_bridge
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_north_bridge
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi

exit 0
